// ==== hw/mod107_defs.svh ====
`ifndef MOD107_DEFS_SVH
`define MOD107_DEFS_SVH

`default_nettype none

// operand geometry.
`define OPERAND_W   100 // operand width in bits.
`define CHUNK_W     6   // width of one chunk.
`define NUM_CHUNKS  16  // weighted chunks above chunk 0.

// fixed modulus of the reducer.
`define MODULUS     107

`default_nettype wire

`endif

// ==== hw/mod107_pkg.sv ====
`include "mod107_defs.svh"

`default_nettype none

package mod107_pkg;

  // full operand as presented at the top level.
  typedef logic [`OPERAND_W-1:0] operand_t;

  // one 6-bit slice of the operand.
  typedef logic [`CHUNK_W-1:0] chunk_t;

  // value below the modulus, for chunk residues and the result.
  typedef logic [$clog2(`MODULUS)-1:0] residue_t;

  // sum of eight chunk residues, at most 848.
  typedef logic [9:0] partial_t;

  // folded value below twice the modulus.
  typedef logic [$clog2(2 * `MODULUS)-1:0] folded_t;

endpackage

`default_nettype wire

// ==== hw/partial_sum_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface partial_sum_if
  import mod107_pkg::*;
();

  logic     valid;     // one cycle per operand.
  partial_t sum_a;     // residues of chunks 1 to 8.
  partial_t sum_b;     // residues of chunks 9 to 16.
  chunk_t   low_chunk; // chunk 0, weight 1.

  modport source (
    output valid,
    output sum_a,
    output sum_b,
    output low_chunk
  );

  modport sink (
    input valid,
    input sum_a,
    input sum_b,
    input low_chunk
  );

endinterface

`default_nettype wire

// ==== hw/chunk_residue.sv ====
`include "mod107_defs.svh"

`timescale 1ns/10ps
`default_nettype none

module chunk_residue
  import mod107_pkg::*;
#(
  parameter int CHUNK_IDX = 1
) (
  input  chunk_t   chunk,
  output residue_t residue
);

  localparam int TABLE_SIZE = 2 ** `CHUNK_W; // one entry per chunk value.
  localparam int RES_W = $bits(residue_t);

  // 2^(6*idx) mod 107, built by repeated doubling.
  function automatic int chunk_weight(input int idx);
    int w;
    w = 1;
    for (int i = 0; i < idx * `CHUNK_W; i++)
    begin
      w = (w * 2) % `MODULUS;
    end
    return w;
  endfunction

  function automatic logic [TABLE_SIZE*RES_W-1:0] build_table(input int idx);
    logic [TABLE_SIZE*RES_W-1:0] tbl;
    int                          w;
    tbl = '0;
    w = chunk_weight(idx);
    for (int c = 0; c < TABLE_SIZE; c++)
    begin
      tbl[c*RES_W +: RES_W] = RES_W'((c * w) % `MODULUS); // residue of c at this weight.
    end
    return tbl;
  endfunction

  localparam logic [TABLE_SIZE*RES_W-1:0] RES_TABLE = build_table(CHUNK_IDX);

  // Plain lookup; synthesis turns the constant table into a small ROM or LUT logic.
  assign residue = RES_TABLE[chunk*RES_W +: RES_W];

endmodule

`default_nettype wire

// ==== hw/chunk_weigher.sv ====
`include "mod107_defs.svh"

`timescale 1ns/10ps
`default_nettype none

module chunk_weigher
  import mod107_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          in_valid,
  input  operand_t      in_operand,
  partial_sum_if.source ps
);

  localparam int TOP_W = `OPERAND_W - `NUM_CHUNKS * `CHUNK_W; // bits in the last chunk.
  localparam int HALF = `NUM_CHUNKS / 2;

  logic     op_valid;
  operand_t op_q;
  residue_t chunk_res [1:`NUM_CHUNKS];
  partial_t sum_a_c;
  partial_t sum_b_c;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      op_valid <= 1'b0;
      op_q     <= '0;
    end
    else
    begin
      op_valid <= in_valid;
      if (in_valid)
        op_q <= in_operand; // edge k.
    end
  end

  // one weighted table per chunk above chunk 0.
  generate
    for (genvar g = 1; g <= `NUM_CHUNKS; g++)
    begin : g_chunk
      chunk_t slice;

      if (g == `NUM_CHUNKS)
      begin : g_top
        assign slice = {{(`CHUNK_W - TOP_W){1'b0}}, op_q[`OPERAND_W-1 -: TOP_W]};
      end
      else
      begin : g_full
        assign slice = op_q[g*`CHUNK_W +: `CHUNK_W];
      end

      chunk_residue #(
        .CHUNK_IDX (g)
      ) u_chunk_residue (
        .chunk   (slice),
        .residue (chunk_res[g])
      );
    end
  endgenerate

  always_comb
  begin
    sum_a_c = '0;
    sum_b_c = '0;
    for (int j = 1; j <= HALF; j++)
    begin
      sum_a_c = sum_a_c + partial_t'(chunk_res[j]);        // chunks 1 to 8.
      sum_b_c = sum_b_c + partial_t'(chunk_res[j + HALF]); // chunks 9 to 16.
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ps.valid     <= 1'b0;
      ps.sum_a     <= '0;
      ps.sum_b     <= '0;
      ps.low_chunk <= '0;
    end
    else
    begin
      ps.valid <= op_valid; // edge k+1.
      if (op_valid)
      begin
        ps.sum_a     <= sum_a_c;
        ps.sum_b     <= sum_b_c;
        ps.low_chunk <= op_q[`CHUNK_W-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/residue_folder.sv ====
`include "mod107_defs.svh"

`timescale 1ns/10ps
`default_nettype none

module residue_folder
  import mod107_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  partial_sum_if.sink ps,
  output logic        fold_valid,
  output folded_t     folded
);

  localparam int FOLD_K = 128 % `MODULUS; // 2^7 mod 107, i.e. 21.

  partial_t lvl1;  // below 465.
  partial_t lvl2;  // below 254.
  partial_t lvl3;  // below 214.

  // keep bits 6:0 and replace each multiple of 128 by 21.
  function automatic partial_t fold_once(input partial_t v);
    partial_t lo;
    partial_t hi;
    lo = {3'b000, v[6:0]};
    hi = {7'b000_0000, v[9:7]};
    return lo + hi * partial_t'(FOLD_K);
  endfunction

  always_comb
  begin
    lvl1 = fold_once(ps.sum_a) + fold_once(ps.sum_b);
    lvl2 = fold_once(lvl1) + partial_t'(ps.low_chunk); // chunk 0 enters here.
    lvl3 = fold_once(lvl2);
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      fold_valid <= 1'b0;
      folded     <= '0;
    end
    else
    begin
      fold_valid <= ps.valid; // edge k+2.
      if (ps.valid)
        folded <= lvl3[$bits(folded_t)-1:0];
    end
  end

endmodule

`default_nettype wire

// ==== hw/residue_output.sv ====
`include "mod107_defs.svh"

`timescale 1ns/10ps
`default_nettype none

module residue_output
  import mod107_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     fold_valid,
  input  folded_t  folded,
  output logic     out_valid,
  output residue_t out_residue
);

  folded_t  reduced;
  residue_t residue_c;

  always_comb
  begin
    if (folded >= folded_t'(`MODULUS))
      reduced = folded - folded_t'(`MODULUS); // one subtraction suffices below 214.
    else
      reduced = folded;
    residue_c = reduced[$bits(residue_t)-1:0];
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_valid   <= 1'b0;
      out_residue <= '0;
    end
    else
    begin
      out_valid <= fold_valid; // edge k+3.
      if (fold_valid)
        out_residue <= residue_c;
    end
  end

endmodule

`default_nettype wire

// ==== hw/mod107_reducer_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module mod107_reducer_top
  import mod107_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  operand_t in_operand,
  output logic     out_valid,
  output residue_t out_residue
);

  partial_sum_if ps_bus ();

  logic    fold_valid;
  folded_t folded;

  chunk_weigher u_chunk_weigher (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_operand (in_operand),
    .ps         (ps_bus.source)
  );

  residue_folder u_residue_folder (
    .clk        (clk),
    .rst_n      (rst_n),
    .ps         (ps_bus.sink),
    .fold_valid (fold_valid),
    .folded     (folded)
  );

  residue_output u_residue_output (
    .clk         (clk),
    .rst_n       (rst_n),
    .fold_valid  (fold_valid),
    .folded      (folded),
    .out_valid   (out_valid),
    .out_residue (out_residue)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 4
) (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever
      #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== testbench/mod107_reducer_chk.sv ====
`include "mod107_defs.svh"

`timescale 1ns/10ps
`default_nettype none

module mod107_reducer_chk
  import mod107_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     in_valid,
  input logic     out_valid,
  input residue_t out_residue
);

  // sampled at edge k, registered out after edge k+3, so seen at the k+4 sample.
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid == $past(in_valid, 4))
    else $error("out_valid does not trail in_valid by the pipeline depth");

  a_range: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> (out_residue < residue_t'(`MODULUS)))
    else $error("out_residue is not below the modulus");

  a_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else $error("out_valid high while reset is asserted");

endmodule

`default_nettype wire

// ==== testbench/mod107_reducer_tb.sv ====
`include "mod107_defs.svh"

`timescale 1ns/10ps
`default_nettype none

module mod107_reducer_tb
  import mod107_pkg::*;
();

  logic       clk;
  logic       rst_n;
  logic       in_valid;
  operand_t   in_operand;
  logic       out_valid;
  residue_t   out_residue;
  logic [3:0] valid_pipe; // in_valid delayed through the four stage registers.
  residue_t   exp_q[$];

  tb_clock_gen #(.PERIOD_NS(4)) u_clock_gen (.clk(clk));

  mod107_reducer_top i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_operand  (in_operand),
    .out_valid   (out_valid),
    .out_residue (out_residue)
  );

  bind mod107_reducer_top mod107_reducer_chk i_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .out_valid   (out_valid),
    .out_residue (out_residue)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "stopping on the first error");
  endtask

  task automatic check_residue(input residue_t got, input residue_t exp);
    if (got !== exp)
      abort_run($sformatf("** Error @ %0d ns: out_residue %0d, expected %0d", $time, got, exp));
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("** Error @ %0d ns: out_valid %b, expected %b", $time, got, exp));
  endtask

  function automatic residue_t ref_mod(input operand_t op);
    return residue_t'(op % operand_t'(`MODULUS));
  endfunction

  function automatic operand_t rand_operand();
    return operand_t'({$urandom, $urandom, $urandom, $urandom});
  endfunction

  task automatic drive_operand(input operand_t op, input residue_t exp);
    @(posedge clk);
    in_valid   <= 1'b1;
    in_operand <= op;
    exp_q.push_back(exp);
  endtask

  task automatic drive_random();
    operand_t op;
    op = rand_operand();
    drive_operand(op, ref_mod(op));
  endtask

  task automatic drive_idle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  task automatic flush_results();
    int n;
    n = 0;
    drive_idle(1);
    while (exp_q.size() != 0)
    begin
      @(posedge clk);
      n++;
      if (n > 20)
        abort_run("timeout: results still outstanding after 20 cycles");
    end
  endtask

  task automatic test_small();
    drive_operand(operand_t'(0), residue_t'(0));
    drive_operand(operand_t'(1), residue_t'(1));
    drive_operand(operand_t'(106), residue_t'(106));
    drive_operand(operand_t'(107), residue_t'(0));
    drive_operand(operand_t'(108), residue_t'(1));
    flush_results();
  endtask

  task automatic test_extremes();
    operand_t op;
    op = '1;
    drive_operand(op, ref_mod(op));
    for (int k = 0; k <= `NUM_CHUNKS; k++)
    begin
      op = operand_t'(1) << (k * `CHUNK_W);
      drive_operand(op, ref_mod(op));
      op = operand_t'({`CHUNK_W{1'b1}}) << (k * `CHUNK_W); // top entry of each table.
      drive_operand(op, ref_mod(op));
    end
    flush_results();
  endtask

  task automatic test_near_multiples();
    operand_t m;
    for (int i = 0; i < 20; i++)
    begin
      m = (rand_operand() >> 7) * operand_t'(`MODULUS); // stays below 2^100.
      drive_operand(m, residue_t'(0));
      if (m != '0)
        drive_operand(m - operand_t'(1), residue_t'(`MODULUS - 1));
    end
    flush_results();
  endtask

  task automatic test_stream_and_gaps();
    repeat (200) drive_random();
    flush_results();
    for (int i = 0; i < 60; i++)
    begin
      drive_random();
      drive_idle(int'($urandom_range(0, 4)));
    end
    flush_results();
  endtask

  task automatic test_mid_reset();
    repeat (10) drive_random();
    @(posedge clk);
    rst_n    <= 1'b0;
    in_valid <= 1'b0;
    exp_q.delete(); // in-flight operands never come out.
    #1;
    check_valid(out_valid, 1'b0);
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    repeat (20) drive_random();
    flush_results();
  endtask

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      valid_pipe <= '0;
    else
      valid_pipe <= {valid_pipe[2:0], in_valid};
  end

  // outputs are stable at the falling edge.
  always @(negedge clk)
  begin
    check_valid(out_valid, valid_pipe[3]);
    if (out_valid)
    begin
      if (exp_q.size() == 0)
        abort_run("out_valid raised with no operand outstanding");
      else
        check_residue(out_residue, exp_q.pop_front());
    end
  end

  initial
  begin
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_operand = '0;
    void'($urandom(32'h93e8_d779));
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    test_small();
    test_extremes();
    test_near_multiples();
    test_stream_and_gaps();
    test_mid_reset();
    drive_idle(6); // a few idle cycles under the valid check.
    if (exp_q.size() == 0)
    begin
      $display("test passed");
      $finish;
    end
    else
    begin
      $display("test failed");
      $fatal(1, "results left in the expected queue");
    end
  end

endmodule

`default_nettype wire

// ==== mod107_reducer.f ====
+incdir+hw
hw/mod107_pkg.sv
hw/partial_sum_if.sv
hw/chunk_residue.sv
hw/chunk_weigher.sv
hw/residue_folder.sv
hw/residue_output.sv
hw/mod107_reducer_top.sv
testbench/tb_clock_gen.sv
testbench/mod107_reducer_chk.sv
testbench/mod107_reducer_tb.sv

// ==== Makefile ====
TOP = mod107_reducer_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/10ps --top-module $(TOP) -f mod107_reducer.f

run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "test failed" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "test passed" sim.log; then echo "simulation stopped early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
